/* hw/cart_loader_top.sv */
// Cartridge loader top level
// Image loader, paced write slot and controller serializer side by side
`default_nettype none

module cart_loader_top (
	input  logic                    clk,
	input  logic                    reset_nes,
	// Host byte stream
	input  logic                    byte_valid,
	input  cart_pkg::byte_t         byte_data,
	input  logic                    invert_mirroring,
	output cart_pkg::credit_t       credit_return,
	// Cartridge memory writes
	output logic                    mem_write,
	output cart_pkg::mem_addr_t     mem_addr,
	output cart_pkg::byte_t         mem_data,
	// Loader status
	output logic                    busy,
	output logic                    done,
	output logic                    error,
	output cart_pkg::mapper_flags_t mapper_flags,
	// Controllers
	input  cart_pkg::pad_t          joy_a,
	input  cart_pkg::pad_t          joy_b,
	input  cart_pkg::pad_t          joy_c,
	input  cart_pkg::pad_t          joy_d,
	input  logic                    swap,
	input  logic                    multitap,
	input  logic                    strobe,
	input  logic [1:0]              joypad_clock,
	output logic [1:0]              joy_data
);
	import cart_pkg::*;

	logic      wr_valid;
	logic      wr_drop;
	mem_addr_t wr_addr;
	byte_t     wr_data;

	rom_loader loader_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.wr_valid         (wr_valid),
		.wr_drop          (wr_drop),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags)
	);

	mem_write_slot slot_i (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.wr_valid      (wr_valid),
		.wr_drop       (wr_drop),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.mem_write     (mem_write),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.credit_return (credit_return)
	);

	joypad_serial joy_i (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_c        (joy_c),
		.joy_d        (joy_d),
		.swap         (swap),
		.multitap     (multitap),
		.strobe       (strobe),
		.joypad_clock (joypad_clock),
		.joy_data     (joy_data)
	);

endmodule

`default_nettype wire

/* hw/cart_pkg.sv */
// Cartridge loader package
// Shared widths, memory map, iNES header constants and loader states
`default_nettype none

package cart_pkg;

	//////////////////////////////
	// Data widths
	//////////////////////////////

	typedef logic [7:0]  byte_t;          // One file or memory byte
	typedef logic [21:0] mem_addr_t;      // Cartridge memory address
	typedef logic [21:0] byte_count_t;    // Bytes left in a segment
	typedef logic [31:0] mapper_flags_t;  // Decoded cartridge configuration
	typedef logic [7:0]  pad_t;           // Pad buttons in host order
	typedef logic [1:0]  credit_t;        // Credits handed back per cycle

	//////////////////////////////
	// Memory map
	//////////////////////////////

	localparam mem_addr_t PRG_BASE    = 22'h000000;
	localparam mem_addr_t CHR_BASE    = 22'h200000;
	localparam mem_addr_t HEADER_BASE = 22'h3FFFF0;  // Scratch copy of the header

	// PRG pages are 16 KiB, CHR pages 8 KiB
	localparam int PRG_PAGE_SHIFT = 14;
	localparam int CHR_PAGE_SHIFT = 13;

	//////////////////////////////
	// iNES header
	//////////////////////////////

	localparam int HEADER_LEN = 16;

	// "NES" followed by EOF, byte 0 in the top byte
	localparam logic [31:0] INES_MAGIC = 32'h4E45531A;

	//////////////////////////////
	// Write pacing
	//////////////////////////////

	localparam int LOAD_CREDITS = 2;  // Also the write queue depth
	localparam int SLOT_PERIOD  = 4;  // One memory slot per CPU divider cycle

	//////////////////////////////
	// Multitap signatures
	//////////////////////////////

	localparam byte_t MULTITAP_SIG_P1 = 8'h08;
	localparam byte_t MULTITAP_SIG_P2 = 8'h04;

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_DONE,
		S_ERROR
	} loader_state_e;

endpackage

`default_nettype wire

/* hw/ines_header.sv */
// iNES header store and decoder
// Keeps the 16 header bytes, checks the magic and builds the mapper flag word
`default_nettype none

module ines_header (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   capture,
	input  logic [3:0]             index,
	input  cart_pkg::byte_t        byte_in,
	input  logic                   invert_mirroring,
	output logic                   magic_ok,
	output logic                   has_trainer,
	output cart_pkg::byte_t        prg_pages,
	output cart_pkg::byte_t        chr_pages,
	output cart_pkg::mapper_flags_t flags
);
	import cart_pkg::*;

	byte_t      hdr [HEADER_LEN];
	logic       is_nes20;
	logic       tail_dirty;
	logic       is_dirty;
	logic [2:0] prg_size;
	logic [2:0] chr_size;
	byte_t      mapper;
	byte_t      submapper;
	logic [3:0] prg_ram_shift;

	// 0 for one page or less, then one step per doubling, 7 above 64 pages
	function automatic logic [2:0] size_code(byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= byte_t'(1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int i = 0; i < HEADER_LEN; i++)
				hdr[i] <= '0;
		end else if (capture) begin
			hdr[index] <= byte_in;
		end
	end

	assign magic_ok    = ({hdr[0], hdr[1], hdr[2], hdr[3]} == INES_MAGIC);
	assign has_trainer = hdr[6][2];
	assign prg_pages   = hdr[4];
	assign chr_pages   = hdr[5];

	// Junk in bytes 9..15 marks an old dumper tool header
	always_comb begin
		tail_dirty = |hdr[9][7:1];
		for (int i = 10; i < HEADER_LEN; i++)
			tail_dirty = tail_dirty | (|hdr[i]);
	end

	assign is_nes20      = (hdr[7][3:2] == 2'b10);
	assign is_dirty      = !is_nes20 && tail_dirty;
	assign prg_size      = size_code(prg_pages);
	assign chr_size      = size_code(chr_pages);
	assign mapper        = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	assign submapper     = is_nes20 ? hdr[8] : 8'h00;
	assign prg_ram_shift = is_nes20 ? hdr[10][3:0] : 4'h0;  // 64 << shift bytes

	// Piano bit stays clear
	assign flags = {1'b0, 1'b0, prg_ram_shift, hdr[6][1], submapper, hdr[6][3],
		(chr_pages == 8'h00), hdr[6][0] ^ invert_mirroring, chr_size, prg_size, mapper};

endmodule

`default_nettype wire

/* hw/joypad_serial.sv */
// Controller serializer
// Latches four pads on strobe and shifts two ports out on falling clocks
`default_nettype none

module joypad_serial (
	input  logic           clk,
	input  logic           reset_nes,
	input  cart_pkg::pad_t joy_a,
	input  cart_pkg::pad_t joy_b,
	input  cart_pkg::pad_t joy_c,
	input  cart_pkg::pad_t joy_d,
	input  logic           swap,
	input  logic           multitap,
	input  logic           strobe,
	input  logic [1:0]     joypad_clock,
	output logic [1:0]     joy_data
);
	import cart_pkg::*;

	byte_t       nes_a;
	byte_t       nes_b;
	byte_t       nes_c;
	byte_t       nes_d;
	logic [23:0] load_word [2];
	logic [23:0] shift_q [2];
	logic [1:0]  last_clock;
	logic [1:0]  clock_fall;

	// Host order to NES order, A button ends up in bit 0
	function automatic byte_t to_nes(pad_t p);
		return {p[0], p[1], p[2], p[3], p[7], p[6], p[5], p[4]};
	endfunction

	assign nes_a = to_nes(joy_a);
	assign nes_b = to_nes(joy_b);
	assign nes_c = to_nes(joy_c);
	assign nes_d = to_nes(joy_d);

	// Without a multitap the extra reads return ones
	always_comb begin
		load_word[0] = {multitap ? {MULTITAP_SIG_P1, nes_c} : 16'hFFFF, swap ? nes_b : nes_a};
		load_word[1] = {multitap ? {MULTITAP_SIG_P2, nes_d} : 16'hFFFF, swap ? nes_a : nes_b};
	end

	assign clock_fall = last_clock & ~joypad_clock;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int p = 0; p < 2; p++)
				shift_q[p] <= '0;
			last_clock <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (strobe)
					shift_q[p] <= load_word[p];
				if (clock_fall[p])
					shift_q[p] <= {1'b0, shift_q[p][23:1]};  // Shift wins over a strobe
			end
			last_clock <= joypad_clock;
		end
	end

	assign joy_data = {shift_q[1][0], shift_q[0][0]};

endmodule

`default_nettype wire

/* hw/mem_write_slot.sv */
// Paced memory write slot
// Queues loader writes and issues one per slot phase, handing credits back
`default_nettype none

module mem_write_slot (
	input  logic                clk,
	input  logic                reset_nes,
	input  logic                wr_valid,
	input  logic                wr_drop,
	input  cart_pkg::mem_addr_t wr_addr,
	input  cart_pkg::byte_t     wr_data,
	output logic                mem_write,
	output cart_pkg::mem_addr_t mem_addr,
	output cart_pkg::byte_t     mem_data,
	output cart_pkg::credit_t   credit_return
);
	import cart_pkg::*;

	// Depth is a power of two so the pointers wrap by themselves
	localparam int PTR_W = $clog2(LOAD_CREDITS);

	mem_addr_t        q_addr [LOAD_CREDITS];
	byte_t            q_data [LOAD_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic [1:0]       phase;      // Slot phase
	logic             slot_open;
	logic             issue;

	assign slot_open = (phase == 2'(SLOT_PERIOD - 1));
	assign issue     = slot_open && (count != '0);

	//////////////////////////////
	// Slot phase and pointers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			phase  <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			phase <= slot_open ? 2'd0 : phase + 2'd1;
			if (wr_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (issue)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop can meet in one cycle
			case ({wr_valid, issue})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Queue storage
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			q_addr[wr_ptr] <= wr_addr;
			q_data[wr_ptr] <= wr_data;
		end
	end

	assign mem_write = issue;
	assign mem_addr  = q_addr[rd_ptr];
	assign mem_data  = q_data[rd_ptr];

	// One credit per issued write plus one per dropped byte
	assign credit_return = {1'b0, issue} + {1'b0, wr_drop};

endmodule

`default_nettype wire

/* hw/rom_loader.sv */
// iNES image loader
// Walks header, PRG and CHR segments and emits one write or drop per byte
`default_nettype none

module rom_loader (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    byte_valid,
	input  cart_pkg::byte_t         byte_data,
	input  logic                    invert_mirroring,
	output logic                    wr_valid,
	output logic                    wr_drop,
	output cart_pkg::mem_addr_t     wr_addr,
	output cart_pkg::byte_t         wr_data,
	output logic                    busy,
	output logic                    done,
	output logic                    error,
	output cart_pkg::mapper_flags_t mapper_flags
);
	import cart_pkg::*;

	loader_state_e state;
	loader_state_e eff_state;
	logic [3:0]    ctr;           // Header byte index
	mem_addr_t     addr_q;
	mem_addr_t     eff_addr;
	byte_count_t   bytes_left;
	byte_count_t   eff_left;
	byte_count_t   prg_bytes;
	byte_count_t   chr_bytes;
	byte_t         prg_pages;
	byte_t         chr_pages;
	logic          magic_ok;
	logic          has_trainer;
	logic          header_capture;

	assign header_capture = byte_valid && (state == S_HEADER);
	assign prg_bytes      = byte_count_t'(prg_pages) << PRG_PAGE_SHIFT;
	assign chr_bytes      = byte_count_t'(chr_pages) << CHR_PAGE_SHIFT;

	ines_header hdr_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.capture          (header_capture),
		.index            (ctr),
		.byte_in          (byte_data),
		.invert_mirroring (invert_mirroring),
		.magic_ok         (magic_ok),
		.has_trainer      (has_trainer),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (mapper_flags)
	);

	// An empty PRG segment falls straight into CHR, so no byte is lost
	// in the switch-over cycle
	always_comb begin
		eff_state = state;
		eff_left  = bytes_left;
		eff_addr  = addr_q;
		if (state == S_PRG && bytes_left == '0) begin
			eff_state = S_CHR;
			eff_left  = chr_bytes;
			eff_addr  = CHR_BASE;
		end
	end

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= S_HEADER;
			ctr        <= '0;
			addr_q     <= PRG_BASE;
			bytes_left <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
			wr_valid   <= 1'b0;
			wr_drop    <= 1'b0;
		end else begin
			wr_valid <= 1'b0;
			wr_drop  <= 1'b0;
			case (eff_state)
				S_HEADER: begin
					if (byte_valid) begin
						wr_valid <= 1'b1;          // Header goes to scratch
						ctr      <= ctr + 4'd1;
						if (ctr == 4'(HEADER_LEN - 1)) begin
							// Trainers are not supported
							if (magic_ok && !has_trainer) begin
								busy       <= 1'b1;
								state      <= S_PRG;
								addr_q     <= PRG_BASE;
								bytes_left <= prg_bytes;
							end else begin
								state <= S_ERROR;
							end
						end
					end
				end
				S_PRG, S_CHR: begin
					if (eff_left != '0) begin
						state      <= eff_state;
						addr_q     <= eff_addr;
						bytes_left <= eff_left;
						if (byte_valid) begin
							wr_valid   <= 1'b1;
							addr_q     <= eff_addr + 1'b1;
							bytes_left <= eff_left - 1'b1;
						end
					end else begin
						state   <= S_DONE;  // CHR exhausted
						busy    <= 1'b0;
						done    <= 1'b1;
						wr_drop <= byte_valid;
					end
				end
				S_DONE: begin
					busy    <= 1'b0;
					done    <= 1'b1;
					wr_drop <= byte_valid;
				end
				S_ERROR: begin
					busy    <= 1'b0;
					done    <= 1'b1;
					error   <= 1'b1;
					wr_drop <= byte_valid;
				end
				default: state <= S_ERROR;
			endcase
		end
	end

	// Write payload follows the byte by one cycle
	always_ff @(posedge clk) begin
		if (byte_valid) begin
			wr_data <= byte_data;
			wr_addr <= (eff_state == S_HEADER) ? HEADER_BASE + mem_addr_t'(ctr) : eff_addr;
		end
	end

endmodule

`default_nettype wire

/* include/tb_cases.svh */
// Stimulus tables for the cartridge loader testbench
// Header rows with page counts and expected flags, then joypad rows
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// Bytes 4 and 5 of the header are taken from the page count columns
typedef struct packed {
	logic [127:0]  header;     // Byte 0 in the top byte
	byte_t         prg_pages;
	byte_t         chr_pages;
	logic          invert;
	logic          bad;        // Header must be rejected
	mapper_flags_t flags;
} load_case_t;

localparam int NUM_LOAD_CASES = 7;

load_case_t load_cases [NUM_LOAD_CASES] = '{
	'{128'h4E45531A_00001B00_00000000_00000000, 8'd1, 8'd1, 1'b0, 1'b0, 32'h02014001},
	'{128'h4E45531A_00004000_00000000_00000000, 8'd0, 8'd2, 1'b1, 1'b0, 32'h00004804},
	'{128'h4E45531A_00002000_00000000_00000000, 8'd1, 8'd0, 1'b0, 1'b0, 32'h00008002},
	'{128'h4E45531A_00005148_03000700_00000000, 8'd0, 8'd0, 1'b0, 1'b0, 32'h1C06C045},
	'{128'h4E45531A_00003070_00000000_44000000, 8'd0, 8'd0, 1'b0, 1'b0, 32'h00008003},
	'{128'h4E455300_00000000_00000000_00000000, 8'd1, 8'd1, 1'b0, 1'b1, 32'h00000000},
	'{128'h4E45531A_00000400_00000000_00000000, 8'd1, 8'd0, 1'b0, 1'b1, 32'h00000000}
};

// Expected port words read out from bit 0
typedef struct packed {
	pad_t        a;
	pad_t        b;
	pad_t        c;
	pad_t        d;
	logic        swap;
	logic        multitap;
	logic [23:0] port0;
	logic [23:0] port1;
} pad_case_t;

localparam int NUM_PAD_CASES = 3;

pad_case_t pad_cases [NUM_PAD_CASES] = '{
	'{8'h01, 8'h10, 8'h0C, 8'hC0, 1'b0, 1'b0, 24'hFFFF80, 24'hFFFF01},  // Plain
	'{8'h01, 8'h10, 8'h0C, 8'hC0, 1'b1, 1'b0, 24'hFFFF01, 24'hFFFF80},  // Swapped
	'{8'h01, 8'h10, 8'h0C, 8'hC0, 1'b0, 1'b1, 24'h083080, 24'h040C01}   // Four players
};

`endif

/* sim/tb_cart_loader.sv */
// Testbench for the cartridge loader top level
// Streams iNES images under credit flow control and reads out the joypad ports
`default_nettype none

module tb_cart_loader;
	import cart_pkg::*;

	`include "tb_cases.svh"

	localparam int EXTRA_BYTES = 4;  // Sent after the image and dropped

	logic          clk;
	logic          reset_nes;
	logic          byte_valid;
	byte_t         byte_data;
	logic          invert_mirroring;
	credit_t       credit_return;
	logic          mem_write;
	mem_addr_t     mem_addr;
	byte_t         mem_data;
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t mapper_flags;
	pad_t          joy_a;
	pad_t          joy_b;
	pad_t          joy_c;
	pad_t          joy_d;
	logic          swap;
	logic          multitap;
	logic          strobe;
	logic [1:0]    joypad_clock;
	logic [1:0]    joy_data;

	int          credits;       // Host side credit counter
	int          writes_seen;
	logic [31:0] lfsr = 32'h557a;
	mem_addr_t   exp_addr [$];
	byte_t       exp_data [$];

	cart_loader_top dut_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.credit_return    (credit_return),
		.mem_write        (mem_write),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags),
		.joy_a            (joy_a),
		.joy_b            (joy_b),
		.joy_c            (joy_c),
		.joy_d            (joy_d),
		.swap             (swap),
		.multitap         (multitap),
		.strobe           (strobe),
		.joypad_clock     (joypad_clock),
		.joy_data         (joy_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[6:0], lfsr[0]};
		end
	endtask

	function automatic byte_t header_byte(load_case_t lc, int i);
		if (i == 4)
			return lc.prg_pages;
		if (i == 5)
			return lc.chr_pages;
		return lc.header[127 - 8*i -: 8];
	endfunction

	// Payload bytes that must land in memory, none for a rejected header
	function automatic int payload_len(load_case_t lc);
		if (lc.bad)
			return 0;
		return (int'(lc.prg_pages) << PRG_PAGE_SHIFT) + (int'(lc.chr_pages) << CHR_PAGE_SHIFT);
	endfunction

	//////////////////////////////
	// Credits and memory model
	//////////////////////////////

	always @(posedge clk) begin
		if (reset_nes) begin
			credits = LOAD_CREDITS;
		end else begin
			credits = credits + int'(credit_return) - int'(byte_valid);
			assert (credits >= 0 && credits <= LOAD_CREDITS) else begin
				$display("Host credit count out of range at %0t: %0d", $time, credits);
				abort_run();
			end
		end
	end

	always @(posedge clk) begin
		if (!reset_nes && mem_write) begin
			assert (exp_addr.size() > 0) else begin
				$display("Memory write at %0t with no byte waiting for it", $time);
				abort_run();
			end
			assert (mem_addr == exp_addr[0]) else begin
				$display("ERR t=%0t mem_addr got %h exp %h", $time, mem_addr, exp_addr[0]);
				abort_run();
			end
			assert (mem_data == exp_data[0]) else begin
				$display("ERR t=%0t mem_data got %h exp %h", $time, mem_data, exp_data[0]);
				abort_run();
			end
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
			writes_seen++;
		end
	end

	task automatic apply_reset();
		reset_nes = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset_nes = 1'b0;
	endtask

	//////////////////////////////
	// Loader rows
	//////////////////////////////

	task automatic run_load_case(input load_case_t lc);
		int         prg_len;
		int         payload;
		int         total;
		int         sent;
		logic [7:0] coin;
		byte_t      b;
		mem_addr_t  a;

		prg_len = int'(lc.prg_pages) << PRG_PAGE_SHIFT;
		payload = payload_len(lc);
		total   = HEADER_LEN + payload + EXTRA_BYTES;
		apply_reset();
		writes_seen      = 0;
		invert_mirroring = lc.invert;
		sent             = 0;
		while (sent < total) begin
			@(posedge clk);
			#1;
			byte_valid = 1'b0;
			if (credits > 0) begin
				draw_bits(1, coin);
				if (coin[0]) begin
					if (sent < HEADER_LEN) begin
						b = header_byte(lc, sent);
						a = HEADER_BASE + mem_addr_t'(sent);
					end else begin
						draw_bits(8, b);
						if (sent - HEADER_LEN < prg_len)
							a = PRG_BASE + mem_addr_t'(sent - HEADER_LEN);
						else
							a = CHR_BASE + mem_addr_t'(sent - HEADER_LEN - prg_len);
					end
					// Loader is busy for the whole payload of a good header
					if (sent >= HEADER_LEN && sent < HEADER_LEN + payload) begin
						assert (busy) else begin
							$display("ERR t=%0t busy got %b exp 1", $time, busy);
							abort_run();
						end
					end
					if (sent < HEADER_LEN + payload) begin  // Extras make no write
						exp_addr.push_back(a);
						exp_data.push_back(b);
					end
					byte_valid = 1'b1;
					byte_data  = b;
					sent++;
				end
			end
		end
		@(posedge clk);
		#1 byte_valid = 1'b0;

		while (!done) begin
			@(posedge clk);
			#1;
		end
		assert (error == lc.bad) else begin
			$display("ERR t=%0t error got %b exp %b", $time, error, lc.bad);
			abort_run();
		end
		assert (!busy) else begin
			$display("ERR t=%0t busy got %b exp 0", $time, busy);
			abort_run();
		end
		if (!lc.bad) begin
			assert (mapper_flags == lc.flags) else begin
				$display("ERR t=%0t mapper_flags got %h exp %h", $time, mapper_flags, lc.flags);
				abort_run();
			end
		end

		// All credits back means the queue has drained
		while (credits != LOAD_CREDITS) begin
			@(posedge clk);
			#1;
		end
		assert (exp_addr.size() == 0) else begin
			$display("Load ended with %0d writes never issued", exp_addr.size());
			abort_run();
		end
		assert (writes_seen == HEADER_LEN + payload) else begin
			$display("ERR t=%0t write count got %0d exp %0d", $time, writes_seen,
				HEADER_LEN + payload);
			abort_run();
		end
	endtask

	//////////////////////////////
	// Joypad rows
	//////////////////////////////

	task automatic run_pad_case(input pad_case_t pc);
		logic [1:0] want;

		joy_a    = pc.a;
		joy_b    = pc.b;
		joy_c    = pc.c;
		joy_d    = pc.d;
		swap     = pc.swap;
		multitap = pc.multitap;
		strobe   = 1'b1;
		@(posedge clk);
		#1 strobe = 1'b0;
		for (int i = 0; i < 24; i++) begin
			want = {pc.port1[i], pc.port0[i]};
			assert (joy_data == want) else begin
				$display("ERR t=%0t joy_data got %b exp %b", $time, joy_data, want);
				abort_run();
			end
			joypad_clock = 2'b11;
			@(posedge clk);
			#1 joypad_clock = 2'b00;  // Falling edge shifts
			@(posedge clk);
			#1;
		end
		assert (joy_data == 2'b00) else begin
			$display("ERR t=%0t joy_data got %b exp 00", $time, joy_data);
			abort_run();
		end
	endtask

	initial begin : watchdog
		int limit;

		limit = 2000 + NUM_PAD_CASES * 60;
		foreach (load_cases[r])
			limit += (HEADER_LEN + EXTRA_BYTES + payload_len(load_cases[r])) * 10;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		abort_run();
	end

	initial begin
		reset_nes        = 1'b1;
		byte_valid       = 1'b0;
		byte_data        = '0;
		invert_mirroring = 1'b0;
		joy_a            = '0;
		joy_b            = '0;
		joy_c            = '0;
		joy_d            = '0;
		swap             = 1'b0;
		multitap         = 1'b0;
		strobe           = 1'b0;
		joypad_clock     = 2'b00;
		apply_reset();
		assert (!busy && !done && !error && !mem_write && credit_return == '0 && joy_data == '0)
		else begin
			$display("Outputs are not idle after reset");
			abort_run();
		end
		foreach (load_cases[r])
			run_load_case(load_cases[r]);
		foreach (pad_cases[r])
			run_pad_case(pad_cases[r]);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
hw/cart_pkg.sv
hw/ines_header.sv
hw/rom_loader.sv
hw/mem_write_slot.sv
hw/joypad_serial.sv
hw/cart_loader_top.sv
sim/tb_cart_loader.sv
